// File: common/ring_pkg.sv
`default_nettype none

package ring_pkg;

  localparam int BUS_AW = 32;
  localparam int BUS_DW = 32;

  // one beat on the chain.
  typedef struct packed {
    logic              req;
    logic              ack;
    logic              write;
    logic [BUS_AW-1:0] addr;
    logic [BUS_DW-1:0] data;
  } bus_msg_t;

  localparam logic [BUS_AW-1:0] JOY_ADDR_BASE = 32'hC100_0100;
  localparam int                JOY_ADDR_SIZE = 5;  // 32 byte window.
  localparam logic [BUS_AW-1:0] LCD_ADDR_BASE = 32'hC200_0000;
  localparam int                LCD_ADDR_SIZE = 8;

  // open request inside [base, base + 2**size).
  function automatic logic bus_claims(input bus_msg_t msg, input logic [BUS_AW-1:0] base,
                                      input int size);
    logic [BUS_AW:0] offs;
    offs = {1'b0, msg.addr} - {1'b0, base};
    return msg.req && !msg.ack && !offs[BUS_AW] && (offs < ((BUS_AW+1)'(1) << size));
  endfunction

endpackage

`default_nettype wire

// File: common/periph_pkg.sv
`default_nettype none

package periph_pkg;

  localparam int ADC_BITS  = 12;
  localparam int ADC_CFG_W = 6;

  // single ended, unipolar, no sleep.
  localparam logic [ADC_CFG_W-1:0] ADC_CFG_CH0 = 6'b100010;
  localparam logic [ADC_CFG_W-1:0] ADC_CFG_CH1 = 6'b110010;

  typedef struct packed {
    logic                valid;
    logic [ADC_BITS-1:0] y;
    logic [ADC_BITS-1:0] x;
  } joy_sample_t;

  typedef struct packed {
    logic [7:0] pad;
    logic [7:0] opcode;
  } lcd_cmd_t;

  // rgb565.
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } lcd_pix_t;

  typedef union packed {
    lcd_cmd_t cmd;
    lcd_pix_t pix;
  } lcd_word_u;

  localparam int unsigned LCD_REG_CMD  = 0;
  localparam int unsigned LCD_REG_PIX  = 4;
  localparam int unsigned LCD_REG_STAT = 8;

endpackage

`default_nettype wire

// File: joystick/adc_sampler.sv
`default_nettype none

module adc_sampler import periph_pkg::*; #(
  parameter int CLK_DIV     = 2,
  parameter int CONV_CYCLES = 8
) (
  input  wire logic  clk,
  input  wire logic  i_rst_n,
  input  wire logic  i_sdo,
  output logic        o_convst,
  output logic        o_sck,
  output logic        o_sdi,
  output joy_sample_t o_sample
);

  localparam int CNT_MAX = (CONV_CYCLES > CLK_DIV) ? CONV_CYCLES : CLK_DIV;
  localparam int CNT_W   = $clog2(CNT_MAX + 1);

  typedef enum logic [1:0] {S_IDLE, S_CONV, S_WAIT, S_SHIFT} state_t;

  state_t              state;
  logic [CNT_W-1:0]    cnt;
  logic [3:0]          bit_cnt;
  logic                sck;
  logic                cfg_ch;  // channel this frame configures.
  logic                primed;
  logic [ADC_BITS-1:0] cfg_sr;
  logic [ADC_BITS-1:0] rx_sr;
  logic                got_x;
  logic                got_y;
  logic [ADC_BITS-1:0] x_q;
  logic [ADC_BITS-1:0] y_q;
  logic                tick;
  logic                frame_done;

  assign tick       = (state == S_SHIFT) && (cnt == CNT_W'(CLK_DIV - 1));
  assign frame_done = tick && sck && (bit_cnt == 4'(ADC_BITS - 1));

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state   <= S_IDLE;
      cnt     <= '0;
      bit_cnt <= '0;
      sck     <= 1'b0;
      cfg_ch  <= 1'b0;
      primed  <= 1'b0;
      cfg_sr  <= '0;
      got_x   <= 1'b0;
      got_y   <= 1'b0;
    end else begin
      case (state)
        S_IDLE: state <= S_CONV;
        S_CONV: begin
          state  <= S_WAIT;
          cnt    <= '0;
          cfg_sr <= {cfg_ch ? ADC_CFG_CH1 : ADC_CFG_CH0, (ADC_BITS - ADC_CFG_W)'(0)};
        end
        S_WAIT: begin
          if (cnt == CNT_W'(CONV_CYCLES - 1)) begin
            state   <= S_SHIFT;
            cnt     <= '0;
            bit_cnt <= '0;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          if (tick) begin
            cnt <= '0;
            sck <= ~sck;
            if (sck) begin  // next sdi bit on the falling edge.
              cfg_sr  <= cfg_sr << 1;
              bit_cnt <= bit_cnt + 1'b1;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
          if (frame_done) begin
            state  <= S_IDLE;
            cfg_ch <= ~cfg_ch;
            primed <= 1'b1;
          end
        end
      endcase
      // result belongs to the channel set up one frame earlier.
      if (frame_done && primed) begin
        if (cfg_ch) got_x <= 1'b1;
        else got_y <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tick && !sck) rx_sr <= {rx_sr[ADC_BITS-2:0], i_sdo};
    if (frame_done && primed) begin
      if (cfg_ch) x_q <= rx_sr;
      else y_q <= rx_sr;
    end
  end

  assign o_convst = (state == S_CONV);
  assign o_sck    = sck;
  assign o_sdi    = cfg_sr[ADC_BITS-1];
  assign o_sample = '{valid: got_x & got_y, y: y_q, x: x_q};

endmodule

`default_nettype wire

// File: joystick/joystick.sv
`default_nettype none

module joystick import ring_pkg::*, periph_pkg::*; #(
  parameter logic [BUS_AW-1:0] ADDR_BASE   = JOY_ADDR_BASE,
  parameter int                SIZE        = JOY_ADDR_SIZE,
  parameter int                CLK_DIV     = 2,
  parameter int                CONV_CYCLES = 8
) (
  input  wire logic     clk,
  input  wire logic     i_rst_n,
  input  wire bus_msg_t i_bus,
  input  wire logic     i_adc_sdo,
  output bus_msg_t      o_bus,
  output logic          o_adc_convst,
  output logic          o_adc_sck,
  output logic          o_adc_sdi
);

  joy_sample_t sample;
  logic        hit;

  adc_sampler #(
    .CLK_DIV     (CLK_DIV),
    .CONV_CYCLES (CONV_CYCLES)
  ) i_adc (
    .clk      (clk),
    .i_rst_n  (i_rst_n),
    .i_sdo    (i_adc_sdo),
    .o_convst (o_adc_convst),
    .o_sck    (o_adc_sck),
    .o_sdi    (o_adc_sdi),
    .o_sample (sample)
  );

  assign hit = bus_claims(i_bus, ADDR_BASE, SIZE);

  // one register stage per hop.
  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_bus <= '0;
    end else begin
      o_bus <= i_bus;
      if (hit) begin
        o_bus.ack <= 1'b1;  // writes acked, data dropped.
        if (!i_bus.write) begin
          o_bus.data <= BUS_DW'(sample);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: display/lcd_spi_tx.sv
`default_nettype none

module lcd_spi_tx import periph_pkg::*; #(
  parameter int CLK_DIV = 2
) (
  input  wire logic      clk,
  input  wire logic      i_rst_n,
  input  wire logic      i_start,
  input  wire lcd_word_u i_word,
  input  wire logic      i_is_pixel,
  output logic           o_busy,
  output logic           o_dc,
  output logic           o_cs,
  output logic           o_sck,
  output logic           o_mosi
);

  localparam int DIV_W = $clog2(CLK_DIV + 1);

  logic [15:0]      sr;
  logic [3:0]       bit_cnt;
  logic [DIV_W-1:0] div_cnt;

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_busy  <= 1'b0;
      o_dc    <= 1'b0;
      o_cs    <= 1'b1;
      o_sck   <= 1'b0;
      sr      <= '0;
      bit_cnt <= '0;
      div_cnt <= '0;
    end else if (!o_busy) begin
      if (i_start) begin
        o_busy  <= 1'b1;
        o_cs    <= 1'b0;
        o_dc    <= i_is_pixel;  // high for pixel data.
        sr      <= i_is_pixel ? 16'(i_word.pix) : {i_word.cmd.opcode, 8'h00};
        bit_cnt <= i_is_pixel ? 4'd15 : 4'd7;
        div_cnt <= '0;
      end
    end else if (div_cnt == DIV_W'(CLK_DIV - 1)) begin
      div_cnt <= '0;
      if (!o_sck) begin
        o_sck <= 1'b1;
      end else begin
        o_sck <= 1'b0;
        if (bit_cnt == 4'd0) begin
          o_busy <= 1'b0;
          o_cs   <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt - 1'b1;
          sr      <= sr << 1;  // new bit on falling sck.
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  assign o_mosi = sr[15];

endmodule

`default_nettype wire

// File: display/st7735r.sv
`default_nettype none

module st7735r import ring_pkg::*, periph_pkg::*; #(
  parameter logic [BUS_AW-1:0] ADDR_BASE = LCD_ADDR_BASE,
  parameter int                SIZE      = LCD_ADDR_SIZE,
  parameter int                CLK_DIV   = 2
) (
  input  wire logic     clk,
  input  wire logic     i_rst_n,
  input  wire bus_msg_t i_bus,
  output bus_msg_t      o_bus,
  output logic          o_dc,
  output logic          o_cs,
  output logic          o_sck,
  output logic          o_mosi
);

  logic              hit;
  logic [BUS_AW-1:0] offs;
  logic              is_cmd;
  logic              is_pix;
  logic              take;
  logic              tx_start;
  logic              tx_busy;
  lcd_word_u         tx_word;
  logic [BUS_DW-1:0] rd_data;

  assign hit    = bus_claims(i_bus, ADDR_BASE, SIZE);
  assign offs   = i_bus.addr - ADDR_BASE;
  assign is_cmd = (offs == BUS_AW'(LCD_REG_CMD));
  assign is_pix = (offs == BUS_AW'(LCD_REG_PIX));

  // a busy transmitter refuses writes, the master retries.
  assign take     = hit && (!i_bus.write || !tx_busy);
  assign tx_start = take && i_bus.write && (is_cmd || is_pix);
  assign tx_word  = i_bus.data[15:0];

  assign rd_data = (offs == BUS_AW'(LCD_REG_STAT)) ? {(BUS_DW - 1)'(0), tx_busy} : '0;

  lcd_spi_tx #(
    .CLK_DIV (CLK_DIV)
  ) i_tx (
    .clk        (clk),
    .i_rst_n    (i_rst_n),
    .i_start    (tx_start),
    .i_word     (tx_word),
    .i_is_pixel (is_pix),
    .o_busy     (tx_busy),
    .o_dc       (o_dc),
    .o_cs       (o_cs),
    .o_sck      (o_sck),
    .o_mosi     (o_mosi)
  );

  always_ff @(posedge clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_bus <= '0;
    end else begin
      o_bus <= i_bus;
      if (take) begin
        o_bus.ack <= 1'b1;
        if (!i_bus.write) begin
          o_bus.data <= rd_data;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/shield.sv
`default_nettype none

module shield import ring_pkg::*; #(
  parameter logic [BUS_AW-1:0] JOY_BASE    = JOY_ADDR_BASE,
  parameter int                JOY_SIZE    = JOY_ADDR_SIZE,
  parameter logic [BUS_AW-1:0] LCD_BASE    = LCD_ADDR_BASE,
  parameter int                LCD_SIZE    = LCD_ADDR_SIZE,
  parameter int                ADC_CLK_DIV = 2,
  parameter int                CONV_CYCLES = 8,
  parameter int                LCD_CLK_DIV = 2
) (
  input  wire logic     clk,
  input  wire logic     i_rst_n,
  input  wire bus_msg_t i_bus,
  input  wire logic     i_adc_sdo,
  output bus_msg_t      o_bus,
  output logic          o_adc_convst,
  output logic          o_adc_sck,
  output logic          o_adc_sdi,
  output logic          o_tft_dc,
  output logic          o_tft_cs,
  output logic          o_tft_sck,
  output logic          o_tft_mosi,
  output logic          o_sd_cs
);

  bus_msg_t joy_to_lcd;

  joystick #(
    .ADDR_BASE   (JOY_BASE),
    .SIZE        (JOY_SIZE),
    .CLK_DIV     (ADC_CLK_DIV),
    .CONV_CYCLES (CONV_CYCLES)
  ) i_joystick (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_bus        (i_bus),
    .i_adc_sdo    (i_adc_sdo),
    .o_bus        (joy_to_lcd),
    .o_adc_convst (o_adc_convst),
    .o_adc_sck    (o_adc_sck),
    .o_adc_sdi    (o_adc_sdi)
  );

  st7735r #(
    .ADDR_BASE (LCD_BASE),
    .SIZE      (LCD_SIZE),
    .CLK_DIV   (LCD_CLK_DIV)
  ) i_display (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_bus   (joy_to_lcd),
    .o_bus   (o_bus),
    .o_dc    (o_tft_dc),
    .o_cs    (o_tft_cs),
    .o_sck   (o_tft_sck),
    .o_mosi  (o_tft_mosi)
  );

  assign o_sd_cs = 1'b1;  // sd card kept deselected.

endmodule

`default_nettype wire

// File: test/shield_assertions.sv
`default_nettype none

module shield_assertions import ring_pkg::*; (
  input wire logic     clk,
  input wire logic     i_rst_n,
  input wire bus_msg_t i_bus,
  input wire logic     i_tft_cs,
  input wire logic     i_tft_sck,
  input wire logic     i_adc_convst
);

  timeunit 1ns;
  timeprecision 100ps;

  int violations = 0;

  ack_has_req: assert property (@(posedge clk) disable iff (!i_rst_n) i_bus.ack |-> i_bus.req)
    else begin
      $error("ack set on the bus output without req");
      violations++;
    end

  // sck parked low between transfers.
  sck_idle: assert property (@(posedge clk) disable iff (!i_rst_n) i_tft_cs |-> !i_tft_sck)
    else begin
      $error("tft sck high while cs is deasserted");
      violations++;
    end

  convst_pulse: assert property (@(posedge clk) disable iff (!i_rst_n)
                                 i_adc_convst |=> !i_adc_convst)
    else begin
      $error("adc convst held longer than one cycle");
      violations++;
    end

endmodule

bind shield shield_assertions i_assertions (
  .clk          (clk),
  .i_rst_n      (i_rst_n),
  .i_bus        (o_bus),
  .i_tft_cs     (o_tft_cs),
  .i_tft_sck    (o_tft_sck),
  .i_adc_convst (o_adc_convst)
);

`default_nettype wire

// File: test/tb_shield.sv
`default_nettype none

module tb_shield import ring_pkg::*, periph_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [BUS_AW-1:0] JOY_BASE = 32'hC100_0100;
  localparam logic [BUS_AW-1:0] LCD_BASE = 32'hC200_0000;
  localparam int JOY_SIZE    = 5;
  localparam int LCD_SIZE    = 8;
  localparam int ADC_CLK_DIV = 2;
  localparam int CONV_CYCLES = 8;
  localparam int LCD_CLK_DIV = 2;
  localparam int FRAME_LEN   = 2 + CONV_CYCLES + 2 * ADC_BITS * ADC_CLK_DIV;
  localparam int XFER_LEN    = 2 + 2 * 16 * LCD_CLK_DIV;
  // an adc case spans up to four frames.
  localparam int CASE_LEN    = (4 * FRAME_LEN > XFER_LEN) ? 4 * FRAME_LEN : XFER_LEN;

  logic     clk = 1'b0;
  logic     i_rst_n;
  bus_msg_t i_bus;
  logic     i_adc_sdo;
  bus_msg_t o_bus;
  logic     o_adc_convst;
  logic     o_adc_sck;
  logic     o_adc_sdi;
  logic     o_tft_dc;
  logic     o_tft_cs;
  logic     o_tft_sck;
  logic     o_tft_mosi;
  logic     o_sd_cs;

  int          cycles = 0;
  int          limit = 0;
  string       kinds[$];
  logic [31:0] arg_a[$];
  logic [31:0] arg_b[$];
  logic [31:0] arg_c[$];

  logic [ADC_BITS-1:0] adc_x = '0;
  logic [ADC_BITS-1:0] adc_y = '0;
  logic [ADC_BITS-1:0] adc_word = '0;
  logic [5:0]          adc_cfg = '0;  // config word seen in the last frame.
  int                  cfg_bits = 0;
  int                  frames = 0;
  logic                adc_sck_q = 1'b0;

  logic [15:0] spi_bits = '0;
  int          spi_n = 0;
  logic        spi_dc = 1'b0;
  logic        tft_sck_q = 1'b0;
  logic        tft_cs_q = 1'b1;
  lcd_word_u   exp_words[$];
  logic        exp_pix[$];

  shield #(
    .JOY_BASE    (JOY_BASE),
    .JOY_SIZE    (JOY_SIZE),
    .LCD_BASE    (LCD_BASE),
    .LCD_SIZE    (LCD_SIZE),
    .ADC_CLK_DIV (ADC_CLK_DIV),
    .CONV_CYCLES (CONV_CYCLES),
    .LCD_CLK_DIV (LCD_CLK_DIV)
  ) i_shield (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_bus        (i_bus),
    .i_adc_sdo    (i_adc_sdo),
    .o_bus        (o_bus),
    .o_adc_convst (o_adc_convst),
    .o_adc_sck    (o_adc_sck),
    .o_adc_sdi    (o_adc_sdi),
    .o_tft_dc     (o_tft_dc),
    .o_tft_cs     (o_tft_cs),
    .o_tft_sck    (o_tft_sck),
    .o_tft_mosi   (o_tft_mosi),
    .o_sd_cs      (o_sd_cs)
  );

  always #2 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string what);
    abort_run($sformatf("[ERROR] %0d ns: %s", $time, what));
  endtask

  task automatic check_bus(input bus_msg_t got, input bus_msg_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf(
        "%s: got req %b ack %b wr %b addr %h data %h, expected ack %b addr %h data %h",
        what, got.req, got.ack, got.write, got.addr, got.data, exp.ack, exp.addr, exp.data));
    end
  endtask

  task automatic check_sample(input joy_sample_t got, input joy_sample_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("joystick sample: got v %b y %h x %h, expected v %b y %h x %h",
        got.valid, got.y, got.x, exp.valid, exp.y, exp.x));
    end
  endtask

  task automatic check_lcd(input lcd_word_u got, input logic got_pix, input int got_bits,
                           input lcd_word_u exp, input logic exp_pix);
    int   exp_bits;
    logic same;
    exp_bits = exp_pix ? 16 : 8;
    // a command only carries the opcode byte.
    same = exp_pix ? (got === exp) : (got.cmd.opcode === exp.cmd.opcode);
    if (got_pix !== exp_pix || got_bits != exp_bits || !same) begin
      report_mismatch($sformatf("spi word: got %0d bits dc %b %h, expected %0d bits dc %b %h",
        got_bits, got_pix, got, exp_bits, exp_pix, exp));
    end
  endtask

  function automatic bus_msg_t make_msg(input logic write, input logic [BUS_AW-1:0] addr,
                                        input logic [BUS_DW-1:0] data);
    bus_msg_t m;
    m = '0;
    m.req = 1'b1;
    m.write = write;
    m.addr = addr;
    m.data = data;
    return m;
  endfunction

  // one beat in, response two cycles later.
  task automatic run_bus_beat(input bus_msg_t m, output bus_msg_t resp);
    @(posedge clk);
    #1 i_bus = m;
    @(posedge clk);
    #1;
    if (o_bus.req) report_mismatch("bus response arrived one cycle early");
    i_bus = '0;
    @(posedge clk);
    #1 resp = o_bus;
  endtask

  task automatic wait_lcd_idle();
    bus_msg_t r;
    logic     busy;
    busy = 1'b1;
    while (busy) begin
      run_bus_beat(make_msg(1'b0, LCD_BASE + LCD_REG_STAT, '0), r);
      busy = !r.ack || r.data[0];
    end
  endtask

  task automatic send_lcd_word(input lcd_word_u w, input logic is_pix);
    bus_msg_t m;
    bus_msg_t r;
    wait_lcd_idle();
    exp_words.push_back(w);
    exp_pix.push_back(is_pix);
    m = make_msg(1'b1, LCD_BASE + (is_pix ? LCD_REG_PIX : LCD_REG_CMD), {16'h0, w});
    run_bus_beat(m, r);
    m.ack = 1'b1;
    check_bus(r, m, is_pix ? "pixel write" : "command write");
  endtask

  task automatic settle_adc(input logic [ADC_BITS-1:0] x, input logic [ADC_BITS-1:0] y);
    joy_sample_t exp;
    bus_msg_t    r;
    int          target;
    adc_x = x;
    adc_y = y;
    target = frames + 3;  // covers both channels with the new values.
    while (frames < target) @(posedge clk);
    r = '0;
    while (r.data[$bits(joy_sample_t)-1] !== 1'b1) begin
      run_bus_beat(make_msg(1'b0, JOY_BASE, '0), r);
    end
    exp.valid = 1'b1;
    exp.y = y;
    exp.x = x;
    check_sample(r.data[$bits(joy_sample_t)-1:0], exp);
  endtask

  task automatic finish_transfer();
    lcd_word_u got;
    lcd_word_u exp_w;
    logic      exp_p;
    if (exp_words.size() == 0) begin
      abort_run("an SPI transfer went out on the display link with no write acked for it");
    end
    got = spi_bits;
    exp_w = exp_words.pop_front();
    exp_p = exp_pix.pop_front();
    check_lcd(got, spi_dc, spi_n, exp_w, exp_p);
  endtask

  task automatic run_case(input string kind, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] c);
    bus_msg_t  m;
    bus_msg_t  r;
    lcd_word_u w;
    w = '0;
    if (kind == "adc") begin
      settle_adc(a[ADC_BITS-1:0], b[ADC_BITS-1:0]);
    end else if (kind == "pix") begin
      w.pix.r = a[4:0];
      w.pix.g = b[5:0];
      w.pix.b = c[4:0];
      send_lcd_word(w, 1'b1);
    end else if (kind == "cmd") begin
      w.cmd.opcode = a[7:0];
      send_lcd_word(w, 1'b0);
    end else begin
      m = make_msg(kind == "wr", a, (kind == "wr") ? b : '0);
      run_bus_beat(m, r);
      m.data = b;  // written data passes, read data is replaced.
      m.ack = c[0];
      check_bus(r, m, {kind, " case"});
    end
  endtask

  task automatic read_cases();
    int          fd;
    int          n;
    int          want;
    string       kind;
    string       rest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("test/shield_cases.txt", "r");
    if (fd == 0) abort_run("could not open test/shield_cases.txt");
    while ($fscanf(fd, "%s", kind) == 1) begin
      a = '0;
      b = '0;
      c = '0;
      if (kind[0] == "#") begin
        n = $fgets(rest, fd);
      end else begin
        want = 3;
        if (kind == "adc") begin
          want = 2;
          n = $fscanf(fd, "%h %h", a, b);
        end else if (kind == "cmd") begin
          want = 1;
          n = $fscanf(fd, "%h", a);
        end else if (kind == "rd" || kind == "wr" || kind == "pix") begin
          n = $fscanf(fd, "%h %h %h", a, b, c);
        end else begin
          abort_run({"unknown case kind in test/shield_cases.txt: ", kind});
        end
        if (n != want) abort_run({"malformed case line of kind ", kind});
        kinds.push_back(kind);
        arg_a.push_back(a);
        arg_b.push_back(b);
        arg_c.push_back(c);
      end
    end
    $fclose(fd);
  endtask

  // the odd/sign bit of the previous config word picks the channel.
  always @(posedge clk) begin
    #1;
    if (o_adc_convst) begin
      adc_word = adc_cfg[4] ? adc_y : adc_x;
      i_adc_sdo = adc_word[ADC_BITS-1];
      cfg_bits = 0;
      frames++;
    end
    if (o_adc_sck && !adc_sck_q && cfg_bits < 6) begin
      adc_cfg = {adc_cfg[4:0], o_adc_sdi};
      cfg_bits++;
    end
    if (!o_adc_sck && adc_sck_q) begin
      adc_word = adc_word << 1;
      i_adc_sdo = adc_word[ADC_BITS-1];
    end
    adc_sck_q = o_adc_sck;
  end

  always @(posedge clk) begin
    #1;
    if (!o_tft_cs && tft_cs_q) begin
      spi_bits = '0;
      spi_n = 0;
    end
    if (!o_tft_cs && o_tft_sck && !tft_sck_q) begin  // mosi is stable on rising sck.
      spi_bits = {spi_bits[14:0], o_tft_mosi};
      spi_n++;
      spi_dc = o_tft_dc;
    end
    if (o_tft_cs && !tft_cs_q) finish_transfer();
    tft_cs_q = o_tft_cs;
    tft_sck_q = o_tft_sck;
  end

  always @(posedge clk) begin
    cycles++;
    if (i_shield.i_assertions.violations != 0) begin
      abort_run("a bound assertion on the shield bus or pins failed");
    end
    if (cycles > limit) begin
      abort_run("timeout: the run went past its cycle limit without finishing");
    end
  end

  initial begin
    i_rst_n = 1'b0;
    i_bus = '0;
    i_adc_sdo = 1'b0;
    read_cases();
    limit = (kinds.size() + 1) * CASE_LEN * 4;
    repeat (16) @(posedge clk);
    #1 i_rst_n = 1'b1;
    check_bus(o_bus, '0, "bus output after reset");
    if (o_tft_cs !== 1'b1 || o_adc_convst !== 1'b0 || o_sd_cs !== 1'b1) begin
      report_mismatch("tft cs, adc convst or sd cs not idle after reset");
    end
    foreach (kinds[i]) run_case(kinds[i], arg_a[i], arg_b[i], arg_c[i]);
    while (exp_words.size() != 0) @(posedge clk);
    if (i_shield.i_assertions.violations == 0) begin
      $display("All tests passed");
      $finish;
    end else begin
      abort_run("bound assertions reported violations during the run");
    end
  end

endmodule

`default_nettype wire

// File: test/shield_cases.txt
# kind and hex fields: adc x y | rd addr data ack | wr addr data ack
# pix r g b | cmd opcode
rd  10000000 00000000 0
wr  30000040 cafef00d 0
adc 5a3 9c1
rd  c1000100 019c15a3 1
rd  c100011c 019c15a3 1
adc 0f0 e07
rd  c1000104 01e070f0 1
wr  c1000100 12345678 1
rd  c1000100 01e070f0 1
rd  c2000008 00000000 1
cmd 2c
pix 1f 2a 05
wr  c2000004 0000aaaa 0
pix 0a 15 1c
cmd 29
rd  c2000008 00000001 1

// File: build.f
common/ring_pkg.sv
common/periph_pkg.sv
joystick/adc_sampler.sv
joystick/joystick.sv
display/lcd_spi_tx.sv
display/st7735r.sv
rtl/shield.sv
test/shield_assertions.sv
test/tb_shield.sv

// File: Bender.yml
package:
  name: shield

sources:
  - common/ring_pkg.sv
  - common/periph_pkg.sv
  - joystick/adc_sampler.sv
  - joystick/joystick.sv
  - display/lcd_spi_tx.sv
  - display/st7735r.sv
  - rtl/shield.sv
  - target: test
    files:
      - test/shield_assertions.sv
      - test/tb_shield.sv
